//--- csr_pkg.sv
package csr_pkg;

   // Operation requested by the caller at start.
   typedef enum logic [2:0] {
      OP_CSRRW = 3'd0, // Read the old value and replace it with the operand.
      OP_CSRRS = 3'd1, // Read the old value and set the operand bits.
      OP_CSRRC = 3'd2, // Read the old value and clear the operand bits.
      OP_TRAP  = 3'd3, // Enter the trap handler.
      OP_MRET  = 3'd4  // Return from the trap handler.
   } csr_op_e;

   // Selects how the written CSR bit is formed from the old bit and the operand.
   typedef enum logic [1:0] {
      SRC_CSR = 2'b00, // The old bit is written back unchanged.
      SRC_EXT = 2'b01, // The operand bit replaces the old bit.
      SRC_SET = 2'b10, // The operand bit is ORed into the old bit.
      SRC_CLR = 2'b11  // The operand bit clears the old bit.
   } csr_source_e;

   // Register selects of the rotating scratch file.
   typedef enum logic [1:0] {
      REG_NONE     = 2'd0, // No scratch register takes part.
      REG_MTVEC    = 2'd1, // Trap vector base.
      REG_MSCRATCH = 2'd2, // Handler scratch word.
      REG_MEPC     = 2'd3  // Exception program counter.
   } csr_reg_e;

   localparam logic [11:0] ADDR_MSTATUS  = 12'h300; // Only MIE is implemented.
   localparam logic [11:0] ADDR_MIE      = 12'h304; // Only MTIE is implemented.
   localparam logic [11:0] ADDR_MTVEC    = 12'h305;
   localparam logic [11:0] ADDR_MSCRATCH = 12'h340;
   localparam logic [11:0] ADDR_MEPC     = 12'h341;
   localparam logic [11:0] ADDR_MCAUSE   = 12'h342; // Bits 3 to 0 and bit 31 only.

   localparam logic [3:0] CAUSE_JUMP   = 4'd0;  // Misaligned jump target.
   localparam logic [3:0] CAUSE_EBREAK = 4'd3;
   localparam logic [3:0] CAUSE_LOAD   = 4'd4;  // Misaligned load address.
   localparam logic [3:0] CAUSE_STORE  = 4'd6;  // Misaligned store address.
   localparam logic [3:0] CAUSE_TIMER  = 4'd7;  // Machine timer interrupt.
   localparam logic [3:0] CAUSE_ECALL  = 4'd11;

endpackage

//--- serial_pkg.sv
package serial_pkg;

   // Every CSR word moves one bit per cycle, LSB first.
   localparam int unsigned WORD_BITS = 32;

   // Width of the bit counter that walks through one word.
   localparam int unsigned CNT_BITS = 5;

   // Counter value at which mstatus.MIE passes by.
   localparam logic [CNT_BITS-1:0] CNT_MIE_BIT = CNT_BITS'(3);

   // Counter value at which mie.MTIE passes by.
   localparam logic [CNT_BITS-1:0] CNT_MTIE_BIT = CNT_BITS'(7);

   // Number of low mcause bits that hold the exception code.
   localparam logic [CNT_BITS-1:0] CNT_CAUSE_LOW = CNT_BITS'(4);

endpackage

//--- serial_counter.sv
`timescale 1ns/1ps

module serial_counter import serial_pkg::*; (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_run,      // Starts a fresh 32-cycle walk at the next edge.
   output logic o_en,       // High for every bit cycle of an operation.
   output logic o_cnt0to3,  // Bits 0 to 3 of the word.
   output logic o_cnt3,     // Bit 3, the mstatus.MIE position.
   output logic o_cnt7,     // Bit 7, the mie.MTIE position.
   output logic o_cnt_done  // Last bit of the word.
);

   logic [CNT_BITS-1:0] count;     // Index of the bit on the serial lines.
   logic                running;   // Set while a word is being walked.
   logic                last_bit;  // Count has reached the top bit.

   assign last_bit = (count == CNT_BITS'(WORD_BITS - 1)); // Bit 31 of the word.

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         running <= 1'b0; // No operation in flight after reset.
         count   <= '0;
      end else if (i_run) begin
         running <= 1'b1; // A start may arrive on the last bit of the previous word.
         count   <= '0;   // The first enabled cycle carries bit 0.
      end else if (running) begin
         count <= count + 1'b1; // Wraps back to zero after bit 31.
         if (last_bit) begin
            running <= 1'b0; // The word is complete.
         end
      end
   end

   // All strobes are qualified by the running flag so that they stay quiet when idle.
   assign o_en       = running;
   assign o_cnt0to3  = running & (count < CNT_CAUSE_LOW);  // Exception code bits.
   assign o_cnt3     = running & (count == CNT_MIE_BIT);   // MIE lives in bit 3.
   assign o_cnt7     = running & (count == CNT_MTIE_BIT);  // MTIE lives in bit 7.
   assign o_cnt_done = running & last_bit;                 // One cycle per operation.

endmodule

//--- csr_sequencer.sv
`timescale 1ns/1ps

module csr_sequencer import csr_pkg::*; (
   input  logic        i_clk,
   input  logic        i_rst,
   input  logic        i_start,      // Start strobe from the caller.
   input  csr_op_e     i_op,
   input  logic [11:0] i_addr,       // CSR address for the CSR instructions.
   input  logic        i_use_imm,    // Take the operand from the immediate stream.
   input  logic        i_en,         // Bit cycle enable from the counter.
   input  logic        i_cnt_done,   // Last bit cycle from the counter.
   output logic        o_run,        // Accepted start, to the counter.
   output logic        o_busy,
   output logic        o_done,
   output logic        o_mstatus_en,
   output logic        o_mie_en,
   output logic        o_mcause_en,
   output csr_source_e o_csr_source,
   output logic        o_csr_d_sel,  // High selects the immediate as operand.
   output logic        o_trap,
   output logic        o_mret,
   output csr_reg_e    o_rd_sel,
   output csr_reg_e    o_wr_sel
);

   csr_op_e     op_r;       // Operation held for the whole word.
   logic [11:0] addr_r;     // Address held for the whole word.
   logic        use_imm_r;  // Operand select held for the whole word.
   logic        csr_access; // One of the three CSR instructions is running.
   csr_reg_e    addr_reg;   // Scratch register named by the held address.
   csr_source_e op_source;  // Write source that belongs to the held operation.

   // A start is taken when idle, or on the last bit so that words run back to back.
   assign o_run = i_start & (~i_en | i_cnt_done);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         op_r      <= OP_CSRRW;
         addr_r    <= '0;
         use_imm_r <= 1'b0;
      end else if (o_run) begin
         op_r      <= i_op;      // Latched once, then held for 32 cycles.
         addr_r    <= i_addr;
         use_imm_r <= i_use_imm;
      end
   end

   assign o_busy = i_en;       // The counter enable spans exactly the word.
   assign o_done = i_cnt_done; // Done marks the final bit cycle.

   assign csr_access = (op_r == OP_CSRRW) | (op_r == OP_CSRRS) | (op_r == OP_CSRRC);

   always_comb begin
      unique case (addr_r)
         ADDR_MTVEC:    addr_reg = REG_MTVEC;
         ADDR_MSCRATCH: addr_reg = REG_MSCRATCH;
         ADDR_MEPC:     addr_reg = REG_MEPC;
         default:       addr_reg = REG_NONE; // Not a scratch register.
      endcase
   end

   always_comb begin
      unique case (op_r)
         OP_CSRRW: op_source = SRC_EXT;
         OP_CSRRS: op_source = SRC_SET;
         OP_CSRRC: op_source = SRC_CLR;
         OP_TRAP:  op_source = SRC_EXT; // The PC stream on rs1 is written into mepc.
         default:  op_source = SRC_CSR; // An mret writes nothing back.
      endcase
   end

   // The decoded controls are gated by busy so that no CSR moves while idle.
   assign o_mstatus_en = i_en & csr_access & (addr_r == ADDR_MSTATUS);
   assign o_mie_en     = i_en & csr_access & (addr_r == ADDR_MIE);
   assign o_mcause_en  = i_en & csr_access & (addr_r == ADDR_MCAUSE);
   assign o_trap       = i_en & (op_r == OP_TRAP);
   assign o_mret       = i_en & (op_r == OP_MRET);
   assign o_csr_source = op_source;
   assign o_csr_d_sel  = csr_access & use_imm_r; // A trap always takes rs1.

   always_comb begin
      o_rd_sel = REG_NONE;
      o_wr_sel = REG_NONE;
      if (i_en) begin
         if (csr_access) begin
            o_rd_sel = addr_reg; // The old value is read and rewritten in place.
            o_wr_sel = addr_reg;
         end else if (op_r == OP_TRAP) begin
            o_rd_sel = REG_MTVEC; // The handler address goes out on o_q.
            o_wr_sel = REG_MEPC;  // The trapping PC is saved.
         end else begin
            o_rd_sel = REG_MEPC; // An mret streams the return address out.
         end
      end
   end

endmodule

//--- serial_csr.sv
`timescale 1ns/1ps

module serial_csr import csr_pkg::*; (
   input  logic        i_clk,
   input  logic        i_rst,
   input  logic        i_trig_irq,   // Samples the timer interrupt condition.
   input  logic        i_en,
   input  logic        i_cnt0to3,
   input  logic        i_cnt3,
   input  logic        i_cnt7,
   input  logic        i_cnt_done,
   input  logic        i_mem_op,     // Trap comes from a misaligned access.
   input  logic        i_mtip,       // Timer interrupt pending level.
   input  logic        i_trap,
   output logic        o_new_irq,    // Fresh timer interrupt to be taken.
   input  logic        i_e_op,       // Trap comes from ecall or ebreak.
   input  logic        i_ebreak,
   input  logic        i_mem_cmd,    // High for a store, low for a load.
   input  logic        i_mstatus_en,
   input  logic        i_mie_en,
   input  logic        i_mcause_en,
   input  csr_source_e i_csr_source,
   input  logic        i_mret,
   input  logic        i_csr_d_sel,
   input  logic        i_rf_csr_out, // Old bit from the scratch file.
   output logic        o_csr_in,     // New bit towards the CSRs.
   input  logic        i_csr_imm,
   input  logic        i_rs1,
   output logic        o_q           // Old bit towards the caller.
);

   logic       mstatus_mie;  // Global machine interrupt enable.
   logic       mstatus_mpie; // MIE as it was before the last trap.
   logic       mie_mtie;     // Timer interrupt enable, write only.
   logic       mcause31;     // Interrupt flag of mcause.
   logic [3:0] mcause3_0;    // Exception code, shifts out LSB first.
   logic       mcause;       // Current serial mcause bit.
   logic       csr_out;      // Current serial old value.
   logic       timer_irq;    // Timer interrupt is pending and enabled.
   logic       timer_irq_r;  // Condition seen at the previous trigger.
   logic       d;            // Operand bit.

   assign d = i_csr_d_sel ? i_csr_imm : i_rs1;

   always_comb begin
      unique case (i_csr_source)
         SRC_EXT: o_csr_in = d;
         SRC_SET: o_csr_in = csr_out | d;
         SRC_CLR: o_csr_in = csr_out & ~d;
         default: o_csr_in = csr_out; // Keep the old bit.
      endcase
   end

   // Only one source is active at a time, so the old bits can simply be ORed.
   assign csr_out = (i_mstatus_en & mstatus_mie & i_cnt3) |
                    i_rf_csr_out |
                    (i_mcause_en & i_en & mcause);
   assign o_q     = csr_out;

   // The code sits in bits 3 to 0 and the interrupt flag in bit 31.
   assign mcause = i_cnt0to3 ? mcause3_0[0] :
                   i_cnt_done ? mcause31 : 1'b0;

   assign timer_irq = i_mtip & mstatus_mie & mie_mtie;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_new_irq    <= 1'b0;
         timer_irq_r  <= 1'b0;
         mie_mtie     <= 1'b0;
         mstatus_mie  <= 1'b0; // Interrupts stay off until software enables them.
         mstatus_mpie <= 1'b0;
      end else begin
         if (i_trig_irq) begin
            timer_irq_r <= timer_irq;
            o_new_irq   <= timer_irq & ~timer_irq_r; // Rising edge since the last trigger.
         end
         if (i_mie_en & i_cnt7) begin
            mie_mtie <= o_csr_in;
         end
         // A trap clears MIE, an mret restores it and a CSR write sets it at bit 3.
         if ((i_trap & i_cnt_done) | (i_mstatus_en & i_cnt3) | i_mret) begin
            mstatus_mie <= ~i_trap & (i_mret ? mstatus_mpie : o_csr_in);
         end
         if (i_trap & i_cnt_done) begin
            mstatus_mpie <= mstatus_mie; // Saved on the same edge that clears MIE.
         end
      end
   end

   /*
    The trap code follows from these patterns.
    A timer interrupt gives 0111, ecall and ebreak give x011,
    a misaligned store or load gives 01x0 and a misaligned jump gives 0000.
    A CSR access shifts the written bits in from the top instead.
   */
   always_ff @(posedge i_clk) begin
      if ((i_mcause_en & i_en & i_cnt0to3) | (i_trap & i_cnt_done)) begin
         mcause3_0[3] <= (i_e_op & ~i_ebreak) | (~i_trap & o_csr_in);
         mcause3_0[2] <= o_new_irq | i_mem_op | (~i_trap & mcause3_0[3]);
         mcause3_0[1] <= o_new_irq | i_e_op | (i_mem_op & i_mem_cmd) |
                         (~i_trap & mcause3_0[2]);
         mcause3_0[0] <= o_new_irq | i_e_op | (~i_trap & mcause3_0[1]);
      end
      if ((i_mcause_en & i_cnt_done) | i_trap) begin
         mcause31 <= i_trap ? o_new_irq : o_csr_in; // Set for interrupts only.
      end
   end

endmodule

//--- csr_scratch_file.sv
`timescale 1ns/1ps

module csr_scratch_file import csr_pkg::*, serial_pkg::*; (
   input  logic     i_clk,
   input  logic     i_en,         // Rotates all registers by one bit.
   input  csr_reg_e i_rd_sel,     // Register whose low bit is read.
   input  csr_reg_e i_wr_sel,     // Register that takes the new bit.
   input  logic     i_csr_in,     // New bit from the CSR data path.
   output logic     o_rf_csr_out  // Old bit of the selected register.
);

   // One full-width word per scratch CSR, indexed by its select value.
   logic [WORD_BITS-1:0] regs [REG_MTVEC:REG_MEPC];

   /*
    Every register rotates right on each enabled cycle. After a whole
    word of 32 cycles each one is back in its original alignment.
    The write target takes the new bit at the top in place of its own
    low bit, so bit k of the stream ends up in bit k.
   */
   always_ff @(posedge i_clk) begin
      for (int i = REG_MTVEC; i <= REG_MEPC; i++) begin
         if (i_en) begin
            regs[i] <= {(i_wr_sel == csr_reg_e'(i)) ? i_csr_in : regs[i][0],
                        regs[i][WORD_BITS-1:1]};
         end
      end
   end

   // The low bit always holds the bit of the current cycle.
   always_comb begin
      if (i_rd_sel == REG_NONE) begin
         o_rf_csr_out = 1'b0; // Lets the other CSR sources through the OR.
      end else begin
         o_rf_csr_out = regs[i_rd_sel][0];
      end
   end

endmodule

//--- csr_unit_top.sv
`timescale 1ns/1ps

module csr_unit_top import csr_pkg::*; (
   input  logic        i_clk,
   input  logic        i_rst,
   input  logic        i_start,    // Start strobe, ignored while busy.
   input  csr_op_e     i_op,
   input  logic [11:0] i_addr,
   input  logic        i_use_imm,
   input  logic        i_rs1,      // Register operand or trapping PC, LSB first.
   input  logic        i_imm,      // Immediate operand, LSB first.
   input  logic        i_e_op,
   input  logic        i_ebreak,
   input  logic        i_mem_op,
   input  logic        i_mem_cmd,
   input  logic        i_mtip,
   input  logic        i_trig_irq,
   output logic        o_busy,
   output logic        o_done,
   output logic        o_q,        // Old CSR value, mtvec on a trap, mepc on an mret.
   output logic        o_new_irq
);

   logic        run;
   logic        en;
   logic        cnt0to3;
   logic        cnt3;
   logic        cnt7;
   logic        cnt_done;
   logic        mstatus_en;
   logic        mie_en;
   logic        mcause_en;
   csr_source_e csr_source;
   logic        csr_d_sel;
   logic        trap;
   logic        mret;
   csr_reg_e    rd_sel;
   csr_reg_e    wr_sel;
   logic        rf_csr_out; // Scratch file to CSR data path.
   logic        csr_in;     // CSR data path to scratch file.

   serial_counter u_counter (
      .i_clk(i_clk), .i_rst(i_rst), .i_run(run), .o_en(en), .o_cnt0to3(cnt0to3),
      .o_cnt3(cnt3), .o_cnt7(cnt7), .o_cnt_done(cnt_done)
   );

   csr_sequencer u_sequencer (
      .i_clk(i_clk), .i_rst(i_rst), .i_start(i_start), .i_op(i_op), .i_addr(i_addr),
      .i_use_imm(i_use_imm), .i_en(en), .i_cnt_done(cnt_done), .o_run(run),
      .o_busy(o_busy), .o_done(o_done), .o_mstatus_en(mstatus_en), .o_mie_en(mie_en),
      .o_mcause_en(mcause_en), .o_csr_source(csr_source), .o_csr_d_sel(csr_d_sel),
      .o_trap(trap), .o_mret(mret), .o_rd_sel(rd_sel), .o_wr_sel(wr_sel)
   );

   serial_csr u_csr (
      .i_clk(i_clk), .i_rst(i_rst), .i_trig_irq(i_trig_irq), .i_en(en),
      .i_cnt0to3(cnt0to3), .i_cnt3(cnt3), .i_cnt7(cnt7), .i_cnt_done(cnt_done),
      .i_mem_op(i_mem_op), .i_mtip(i_mtip), .i_trap(trap), .o_new_irq(o_new_irq),
      .i_e_op(i_e_op), .i_ebreak(i_ebreak), .i_mem_cmd(i_mem_cmd),
      .i_mstatus_en(mstatus_en), .i_mie_en(mie_en), .i_mcause_en(mcause_en),
      .i_csr_source(csr_source), .i_mret(mret), .i_csr_d_sel(csr_d_sel),
      .i_rf_csr_out(rf_csr_out), .o_csr_in(csr_in), .i_csr_imm(i_imm), .i_rs1(i_rs1),
      .o_q(o_q)
   );

   csr_scratch_file u_scratch (
      .i_clk(i_clk), .i_en(en), .i_rd_sel(rd_sel), .i_wr_sel(wr_sel),
      .i_csr_in(csr_in), .o_rf_csr_out(rf_csr_out)
   );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS = 100 // Full clock period in nanoseconds.
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0; // The first rising edge comes half a period in.
   end

   always begin
      #(PERIOD_NS / 2) o_clk = ~o_clk; // Even duty cycle.
   end

endmodule

//--- csr_unit_assertions.sv
`timescale 1ns/1ps

module csr_unit_assertions (
   input logic i_clk,
   input logic i_rst,
   input logic i_mtip,     // Timer interrupt level at the top.
   input logic i_trig_irq, // Interrupt trigger strobe at the top.
   input logic i_busy,     // Top o_busy.
   input logic i_done,     // Top o_done.
   input logic i_new_irq   // Top o_new_irq.
);

   int error_count = 0; // Failed assertion count.

   // Done marks the last bit cycle, which always lies inside the busy window.
   assert property (@(posedge i_clk) disable iff (i_rst) i_done |-> i_busy)
      else begin
         $error("o_done is high while o_busy is low.");
         error_count++;
      end

   // Every word is exactly 32 bit cycles long.
   assert property (@(posedge i_clk) disable iff (i_rst) $rose(i_busy) |-> ##31 i_done)
      else begin
         $error("o_done did not follow the rise of o_busy after 31 cycles.");
         error_count++;
      end

   // The interrupt flag only moves on a trigger, and only rises with mtip pending.
   assert property (@(posedge i_clk) disable iff (i_rst)
                    $rose(i_new_irq) |-> $past(i_trig_irq) && $past(i_mtip))
      else begin
         $error("o_new_irq rose without a trigger while mtip was high.");
         error_count++;
      end

endmodule

bind csr_unit_top csr_unit_assertions u_assertions (
   .i_clk(i_clk),
   .i_rst(i_rst),
   .i_mtip(i_mtip),
   .i_trig_irq(i_trig_irq),
   .i_busy(o_busy),
   .i_done(o_done),
   .i_new_irq(o_new_irq)
);

//--- tb_csr_unit.sv
`timescale 1ns/1ps

module tb_csr_unit import csr_pkg::*, serial_pkg::*; ();

   localparam int CLK_PERIOD_NS = 100;
   localparam int MAX_VECTORS   = 64;
   localparam int CYCLES_PER_OP = 40; // Budget per vector for the watchdog.

   logic        i_clk;
   logic        i_rst;
   logic        i_start;
   csr_op_e     i_op;
   logic [11:0] i_addr;
   logic        i_use_imm;
   logic        i_rs1;
   logic        i_imm;
   logic        i_e_op;
   logic        i_ebreak;
   logic        i_mem_op;
   logic        i_mem_cmd;
   logic        i_mtip;
   logic        i_trig_irq;
   logic        o_busy;
   logic        o_done;
   logic        o_q;
   logic        o_new_irq;

   logic [2:0]  vec_op    [MAX_VECTORS];
   logic [11:0] vec_addr  [MAX_VECTORS];
   logic        vec_imm   [MAX_VECTORS];
   logic [31:0] vec_opnd  [MAX_VECTORS];
   logic [3:0]  vec_cause [MAX_VECTORS]; // {e_op, ebreak, mem_op, mem_cmd}.
   logic        vec_mtip  [MAX_VECTORS];
   logic        vec_trig  [MAX_VECTORS];
   logic        vec_irq   [MAX_VECTORS]; // Expected o_new_irq after the trigger phase.
   logic        vec_chk   [MAX_VECTORS]; // Low when the old value is still unknown.
   logic [31:0] vec_exp   [MAX_VECTORS];
   int          vec_count;
   int          done_count;
   logic        vectors_loaded;

   tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clock (.o_clk(i_clk));

   csr_unit_top dut0 (.*);

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
         $display("Test FAILED");
         $fatal(1, "Stopping at the first mismatch.");
      end
   endtask

   task automatic load_vectors();
      int    fd;
      int    fields;
      string line;
      int    op_v, imm_v, mtip_v, trig_v, irq_v, chk_v;
      logic [11:0] addr_v;
      logic [31:0] opnd_v, exp_v;
      logic [3:0]  cause_v;
      fd = $fopen("csr_unit_vectors.txt", "r");
      if (fd == 0) begin
         $display("The vector file csr_unit_vectors.txt could not be opened.");
         $display("Test FAILED");
         $fatal(1, "No stimulus available.");
      end
      vec_count = 0;
      while (!$feof(fd) && vec_count < MAX_VECTORS) begin
         line = "";
         void'($fgets(line, fd));
         fields = $sscanf(line, "%d %h %d %h %h %d %d %d %d %h", op_v, addr_v, imm_v,
                          opnd_v, cause_v, mtip_v, trig_v, irq_v, chk_v, exp_v);
         if (fields == 10) begin // Comment and blank lines do not parse.
            vec_op[vec_count]    = op_v[2:0];
            vec_addr[vec_count]  = addr_v;
            vec_imm[vec_count]   = imm_v[0];
            vec_opnd[vec_count]  = opnd_v;
            vec_cause[vec_count] = cause_v;
            vec_mtip[vec_count]  = mtip_v[0];
            vec_trig[vec_count]  = trig_v[0];
            vec_irq[vec_count]   = irq_v[0];
            vec_chk[vec_count]   = chk_v[0];
            vec_exp[vec_count]   = exp_v;
            vec_count++;
         end
      end
      $fclose(fd);
      if (vec_count == 0) begin
         $display("The vector file csr_unit_vectors.txt holds no usable lines.");
         $display("Test FAILED");
         $fatal(1, "No stimulus available.");
      end
   endtask

   // One vector: optional trigger, a start, then 32 serial bit cycles.
   task automatic run_vector(input int idx);
      logic [31:0] word;
      logic [31:0] opnd;
      int          done_at;
      word    = '0;
      opnd    = vec_opnd[idx];
      done_at = -1;
      @(posedge i_clk);
      i_mtip     <= vec_mtip[idx];
      i_trig_irq <= vec_trig[idx]; // Single cycle strobe.
      @(posedge i_clk);
      i_trig_irq <= 1'b0;
      i_start    <= 1'b1;
      i_op       <= csr_op_e'(vec_op[idx]);
      i_addr     <= vec_addr[idx];
      i_use_imm  <= vec_imm[idx];
      {i_e_op, i_ebreak, i_mem_op, i_mem_cmd} <= vec_cause[idx]; // Held for the whole word.
      @(negedge i_clk);
      check_value("o_new_irq", o_new_irq, vec_irq[idx]);
      check_value("o_busy", o_busy, 1'b0);
      for (int k = 0; k < WORD_BITS; k++) begin
         @(posedge i_clk);
         i_start <= (k == 15); // A second start in the middle of the word must be ignored.
         // The unused stream carries the complement so a wrong select shows up.
         i_rs1   <= vec_imm[idx] ? ~opnd[k] : opnd[k];
         i_imm   <= vec_imm[idx] ? opnd[k] : ~opnd[k];
         @(negedge i_clk);
         word[k] = o_q;
         check_value("o_busy", o_busy, 1'b1);
         if (o_done === 1'b1 && done_at < 0) begin
            done_at = k + 1; // Cycles counted from the edge that took the start.
         end
      end
      check_value("start to o_done cycles", done_at, WORD_BITS);
      if (vec_chk[idx]) begin
         check_value("o_q", word, vec_exp[idx]);
      end
   endtask

   always @(negedge i_clk) begin
      if (o_done === 1'b1) begin
         done_count++; // Every accepted start ends in exactly one done pulse.
      end
      check_value("assertion failures", dut0.u_assertions.error_count, 0);
   end

   initial begin : watchdog
      wait (vectors_loaded);
      #((vec_count + 4) * CYCLES_PER_OP * CLK_PERIOD_NS);
      $display("Timeout: the vectors did not complete in the expected number of cycles.");
      $display("Test FAILED");
      $fatal(1, "Watchdog expired.");
   end

   initial begin : main
      i_rst          = 1'b1;
      i_start        = 1'b0;
      i_op           = OP_CSRRW;
      i_addr         = '0;
      i_use_imm      = 1'b0;
      i_rs1          = 1'b0;
      i_imm          = 1'b0;
      i_e_op         = 1'b0;
      i_ebreak       = 1'b0;
      i_mem_op       = 1'b0;
      i_mem_cmd      = 1'b0;
      i_mtip         = 1'b0;
      i_trig_irq     = 1'b0;
      done_count     = 0;
      vectors_loaded = 1'b0;
      load_vectors();
      vectors_loaded = 1'b1;
      repeat (2) @(posedge i_clk);
      i_rst <= 1'b0; // Reset covered two rising edges.
      @(negedge i_clk);
      check_value("o_busy", o_busy, 1'b0);
      check_value("o_done", o_done, 1'b0);
      check_value("o_new_irq", o_new_irq, 1'b0);
      for (int idx = 0; idx < vec_count; idx++) begin
         run_vector(idx);
      end
      @(negedge i_clk);
      check_value("done pulse count", done_count, vec_count);
      check_value("assertion failures", dut0.u_assertions.error_count, 0);
      $display("Test OK");
      $finish;
   end

endmodule

//--- csr_unit_vectors.txt
# op(0 rw,1 rs,2 rc,3 trap,4 mret) addr imm operand cause(e_op ebreak mem_op mem_cmd)
# mtip trig irq(expected o_new_irq) chk(compare o_q) expected_o_q
0 340 0 12345678 0 0 0 0 0 00000000
0 340 1 a5a5f00f 0 0 0 0 1 12345678
1 340 0 00000ff0 0 0 0 0 1 a5a5f00f
2 340 1 ffff0000 0 0 0 0 1 a5a5ffff
1 340 0 00000000 0 0 0 0 1 0000ffff
0 305 0 80000100 0 0 0 0 0 00000000
1 305 1 0000000c 0 0 0 0 1 80000100
2 305 0 0000000c 0 0 0 0 1 8000010c
0 341 0 00001000 0 0 0 0 0 00000000
1 341 0 00000000 0 0 0 0 1 00001000
1 300 0 ffffffff 0 0 0 0 1 00000000
1 300 0 00000000 0 0 0 0 1 00000008
2 300 1 00000008 0 0 0 0 1 00000008
1 300 0 00000000 0 0 0 0 1 00000000
0 304 0 00000080 0 0 0 0 1 00000000
0 304 1 00000080 0 0 0 0 1 00000000
1 300 1 00000008 0 0 0 0 1 00000000
3 000 0 00002468 8 0 0 0 1 80000100
1 342 0 00000000 0 0 0 0 1 0000000b
1 300 0 00000000 0 0 0 0 1 00000000
1 341 0 00000000 0 0 0 0 1 00002468
4 000 0 00000000 0 0 0 0 1 00002468
1 300 0 00000000 0 0 0 0 1 00000008
3 000 0 00003000 c 0 0 0 1 80000100
1 342 0 00000000 0 0 0 0 1 00000003
3 000 0 0000300c 3 0 0 0 1 80000100
1 342 0 00000000 0 0 0 0 1 00000006
3 000 0 00003010 2 0 0 0 1 80000100
1 342 0 00000000 0 0 0 0 1 00000004
3 000 0 00003014 0 0 0 0 1 80000100
1 342 0 00000000 0 0 0 0 1 00000000
1 341 0 00000000 0 0 0 0 1 00003014
1 300 1 00000008 0 0 0 0 1 00000000
0 304 0 00000080 0 0 0 0 1 00000000
3 000 0 00004000 0 1 1 1 1 80000100
1 342 0 00000000 0 1 1 0 1 80000007
1 300 0 00000000 0 1 0 0 1 00000000
1 300 1 00000008 0 1 0 0 1 00000000
1 300 0 00000000 0 1 1 1 1 00000008
1 300 0 00000000 0 1 1 0 1 00000008
1 300 0 00000000 0 0 1 0 1 00000008

//--- project.f
csr_pkg.sv
serial_pkg.sv
serial_counter.sv
csr_sequencer.sv
serial_csr.sv
csr_scratch_file.sv
csr_unit_top.sv
tb_clock_gen.sv
csr_unit_assertions.sv
tb_csr_unit.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - csr_pkg.sv
  - serial_pkg.sv
  - serial_counter.sv
  - csr_sequencer.sv
  - serial_csr.sv
  - csr_scratch_file.sv
  - csr_unit_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - csr_unit_assertions.sv
      - tb_csr_unit.sv
